// File: verilog.f
+incdir+bench
verilog/scope_sample_pkg.sv
verilog/scope_acq_pkg.sv
verilog/downsampler.sv
verilog/threshold_trigger.sv
verilog/acq_ctrl.sv
verilog/sample_ram.sv
verilog/scope_top.sv
bench/tb_scope.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   -f verilog.f --top-module tb_scope -o tb_scope
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_scope > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
   exit 0
fi
exit 1

// File: bench/scope_model.svh
`ifndef SCOPE_MODEL_SVH
`define SCOPE_MODEL_SVH

// Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(logic [31:0] s);
   return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(int n);
   logic [31:0] r;
   r = '0;
   for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
   end
   return r;
endfunction

// Offset binary code minus midscale
function automatic sample_t code_to_sample(adc_code_t c);
   return sample_t'(int'(c) - 512);
endfunction

// Reference decimated samples for the current stream
function automatic void build_model(int ds, bit hr);
   int sum;
   n_ref = STREAM_LEN >> ds;
   for (int j = 0; j < n_ref; j++) begin
      sum = 0;
      for (int k = 0; k < (1 << ds); k++) begin
         sum += int'(code_to_sample(stream[(j << ds) + k]));
      end
      // Average by arithmetic shift, pick takes the group's first input
      ref_smp[j] = hr ? sample_t'(sum >>> ds) : code_to_sample(stream[j << ds]);
   end
endfunction

// Index of the trigger sample among armed samples, or -1
function automatic int find_trigger(int pre, int lower, int upper);
   bit below;
   below = 1'b0;
   for (int j = pre; j < n_ref; j++) begin
      if (below && int'(ref_smp[j]) >= upper) begin
         return j;
      end
      if (int'(ref_smp[j]) <= lower) begin
         below = 1'b1;
      end
   end
   return -1;
endfunction

task automatic report_error(string msg);
   errors++;
   $display("ERROR: %s", msg);
endtask

task automatic check_sample(string name, sample_t got, sample_t exp);
   if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
   end
endtask

task automatic check_state(string name, acq_state_t got, acq_state_t exp);
   if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
   end
endtask

task automatic check_addr(string name, logic [ADDR_W-1:0] got, logic [ADDR_W-1:0] exp);
   if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
   end
endtask

task automatic check_count(string name, event_count_t got, event_count_t exp);
   if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
   end
endtask

`endif

// File: bench/tb_scope.sv
module tb_scope
   import scope_sample_pkg::*;
   import scope_acq_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ADDR_W     = 10;
   localparam int STREAM_LEN = 4096;

   logic              lvds_clk_slow_clkin;
   logic              rst_n;
   adc_code_t         rx_data;
   logic              trigger_live;
   ds_shift_t         downsample;
   logic              highres;
   sample_t           lowerthresh;
   sample_t           upperthresh;
   len_t              prelengthtotake;
   len_t              lengthtotake;
   logic [ADDR_W-1:0] rd_addr;
   sample_t           rd_data;
   acq_state_t        acqstate;
   logic [ADDR_W-1:0] ram_address_triggered;
   event_count_t      eventcounter;

   // Model state with the ADC input stream and the expected decimated samples
   logic [31:0] lfsr;
   adc_code_t   stream [STREAM_LEN];
   sample_t     ref_smp [STREAM_LEN];
   int          n_ref;
   int          errors;
   int          exp_events;
   int          wptr;

   `include "scope_model.svh"

   scope_top #(.ADDR_W(ADDR_W)) dut0 (.*);

   always #10 lvds_clk_slow_clkin = ~lvds_clk_slow_clkin;

   task automatic fill_random();
      for (int i = 0; i < STREAM_LEN; i++) begin
         stream[i] = adc_code_t'(rand_bits(10));
      end
   endtask

   // Read data shows up one cycle after the address
   task automatic read_word(input logic [ADDR_W-1:0] addr, output sample_t data);
      @(posedge lvds_clk_slow_clkin);
      rd_addr <= addr;
      repeat (2) @(posedge lvds_clk_slow_clkin);
      data = rd_data;
   endtask

   task automatic wait_state(acq_state_t st, int limit);
      int n;
      n = 0;
      while (acqstate !== st && n < limit) begin
         @(posedge lvds_clk_slow_clkin);
         n++;
      end
      if (acqstate !== st) begin
         report_error($sformatf("timeout waiting for acquisition state %0d", st));
      end
   endtask

   task automatic run_record(int ds, bit hr, int lower, int upper, int pre, int post);
      int                t;
      int                idx;
      logic [ADDR_W-1:0] a_exp;
      sample_t           got;
      @(posedge lvds_clk_slow_clkin);
      downsample      <= ds_shift_t'(ds);
      highres         <= hr;
      lowerthresh     <= sample_t'(lower);
      upperthresh     <= sample_t'(upper);
      prelengthtotake <= len_t'(pre);
      lengthtotake    <= len_t'(post);
      build_model(ds, hr);
      t = find_trigger(pre, lower, upper);
      if (t < 0 || t + post + 4 > n_ref) begin
         report_error("stimulus holds no complete triggered record");
         return;
      end
      a_exp = ADDR_W'(wptr + t);
      exp_events++;
      @(posedge lvds_clk_slow_clkin);
      trigger_live <= 1'b1;
      // Restart comes one cycle later and the stream starts with it
      idx = 0;
      @(posedge lvds_clk_slow_clkin);
      while (acqstate !== ACQ_DONE && idx < STREAM_LEN) begin
         rx_data <= stream[idx];
         idx++;
         @(posedge lvds_clk_slow_clkin);
      end
      if (acqstate !== ACQ_DONE) begin
         report_error("timeout waiting for the record to complete");
      end
      check_addr("ram_address_triggered", ram_address_triggered, a_exp);
      check_count("eventcounter", eventcounter, event_count_t'(exp_events));
      for (int k = 0; k <= pre + post; k++) begin
         read_word(ADDR_W'(int'(a_exp) - pre + k), got);
         check_sample("rd_data", got, ref_smp[t - pre + k]);
      end
      wptr = (wptr + t + post + 1) % (1 << ADDR_W);
      @(posedge lvds_clk_slow_clkin);
      trigger_live <= 1'b0;
      wait_state(ACQ_IDLE, 10);
   endtask

   initial begin
      int ds;
      bit hr;
      lfsr                = 32'h03976c65;
      errors              = 0;
      exp_events          = 0;
      wptr                = 0;
      lvds_clk_slow_clkin = 1'b0;
      rst_n               = 1'b0;
      rx_data             = ADC_MIDSCALE;
      trigger_live        = 1'b0;
      downsample          = '0;
      highres             = 1'b0;
      lowerthresh         = '0;
      upperthresh         = '0;
      prelengthtotake     = '0;
      lengthtotake        = '0;
      rd_addr             = '0;
      repeat (4) @(posedge lvds_clk_slow_clkin);
      rst_n <= 1'b1;

      repeat (20) begin
         @(posedge lvds_clk_slow_clkin);
         check_state("acqstate", acqstate, ACQ_IDLE);
      end
      check_count("eventcounter", eventcounter, '0);

      // Pick mode
      fill_random();
      run_record(0, 1'b0, -200, 200, 20, 30);
      fill_random();
      run_record(2, 1'b0, -200, 200, 16, 40);

      // High resolution averaging over groups of 8
      fill_random();
      run_record(3, 1'b1, -60, 60, 12, 24);

      // A high level before any low sample must not fire but the edge at 16 must
      fill_random();
      for (int i = 0; i < 17; i++) begin
         stream[i] = adc_code_t'(512);
      end
      for (int i = 4; i < 10; i++) begin
         stream[i] = adc_code_t'(812);
      end
      stream[11] = adc_code_t'(212);
      stream[16] = adc_code_t'(812);
      run_record(0, 1'b0, -100, 100, 4, 8);

      // Back to back records with enough writes to wrap the RAM
      for (int r = 0; r < 5; r++) begin
         fill_random();
         ds = int'(rand_bits(2)) % 3;
         hr = (rand_bits(1) != 32'd0);
         run_record(ds, hr, hr ? -60 : -200, hr ? 60 : 200,
                    100 + int'(rand_bits(7)), 150 + int'(rand_bits(8)));
      end

      $display("Checks done: %0d errors over %0d records", errors, exp_events);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: verilog/scope_top.sv
module scope_top
   import scope_sample_pkg::*;
   import scope_acq_pkg::*;
#(
   parameter int ADDR_W = 10
) (
   input  logic              lvds_clk_slow_clkin,
   input  logic              rst_n,
   input  adc_code_t         rx_data,
   input  logic              trigger_live,
   input  ds_shift_t         downsample,
   input  logic              highres,
   input  sample_t           lowerthresh,
   input  sample_t           upperthresh,
   input  len_t              prelengthtotake,
   input  len_t              lengthtotake,
   input  logic [ADDR_W-1:0] rd_addr,
   output sample_t           rd_data,
   output acq_state_t        acqstate,
   output logic [ADDR_W-1:0] ram_address_triggered,
   output event_count_t      eventcounter
);

   // Decimated stream
   sample_t sample;
   logic    sample_valid;

   // Control between trigger and acquisition FSM
   logic restart;
   logic armed;
   logic trig;

   // RAM write port
   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   sample_t           wr_data;

   downsampler downsampler_inst (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .rx_data(rx_data),
      .restart(restart),
      .downsample(downsample),
      .highres(highres),
      .sample(sample),
      .sample_valid(sample_valid)
   );

   threshold_trigger threshold_trigger_inst (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .sample(sample),
      .sample_valid(sample_valid),
      .armed(armed),
      .lowerthresh(lowerthresh),
      .upperthresh(upperthresh),
      .trig(trig)
   );

   acq_ctrl #(
      .ADDR_W(ADDR_W)
   ) acq_ctrl_inst (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .rst_n(rst_n),
      .trigger_live(trigger_live),
      .prelengthtotake(prelengthtotake),
      .lengthtotake(lengthtotake),
      .sample(sample),
      .sample_valid(sample_valid),
      .trig(trig),
      .restart(restart),
      .armed(armed),
      .wr_en(wr_en),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .acqstate(acqstate),
      .ram_address_triggered(ram_address_triggered),
      .eventcounter(eventcounter)
   );

   sample_ram #(
      .ADDR_W(ADDR_W),
      .payload_t(sample_t)
   ) sample_ram_inst (
      .lvds_clk_slow_clkin(lvds_clk_slow_clkin),
      .wr_en(wr_en),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .rd_addr(rd_addr),
      .rd_data(rd_data)
   );

endmodule

// File: verilog/sample_ram.sv
module sample_ram #(
   parameter int  ADDR_W    = 10,
   parameter type payload_t = logic [15:0]
) (
   input  logic              lvds_clk_slow_clkin,
   input  logic              wr_en,
   input  logic [ADDR_W-1:0] wr_addr,
   input  payload_t          wr_data,
   input  logic [ADDR_W-1:0] rd_addr,
   output payload_t          rd_data
);

   localparam int DEPTH = 2 ** ADDR_W;

   payload_t mem [DEPTH];

   // Write port
   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // Registered read, old data on a same-address collision
   always_ff @(posedge lvds_clk_slow_clkin) begin
      rd_data <= mem[rd_addr];
   end

   // Write address comes from the acquisition pointer
   a_wr_addr_known : assert property (
      @(posedge lvds_clk_slow_clkin)
      wr_en |-> !$isunknown(wr_addr)
   );

endmodule

// File: verilog/acq_ctrl.sv
module acq_ctrl
   import scope_sample_pkg::*;
   import scope_acq_pkg::*;
#(
   parameter int ADDR_W = 10
) (
   input  logic              lvds_clk_slow_clkin,
   input  logic              rst_n,
   input  logic              trigger_live,
   input  len_t              prelengthtotake,
   input  len_t              lengthtotake,
   input  sample_t           sample,
   input  logic              sample_valid,
   input  logic              trig,
   output logic              restart,
   output logic              armed,
   output logic              wr_en,
   output logic [ADDR_W-1:0] wr_addr,
   output sample_t           wr_data,
   output acq_state_t        acqstate,
   output logic [ADDR_W-1:0] ram_address_triggered,
   output event_count_t      eventcounter
);

   logic live_q;
   logic post_q;
   len_t cnt_q;
   len_t cnt_next;

   // Trigger search only until the trigger sample is seen
   assign armed = (acqstate == ACQ_ARMED) && !post_q;

   // Writes follow the strobe in the same cycle
   assign wr_en    = sample_valid && (acqstate == ACQ_PRE || acqstate == ACQ_ARMED);
   assign wr_data  = sample;
   assign cnt_next = cnt_q + len_t'(1);

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         acqstate              <= ACQ_IDLE;
         live_q                <= 1'b0;
         restart               <= 1'b0;
         post_q                <= 1'b0;
         cnt_q                 <= '0;
         wr_addr               <= '0;
         ram_address_triggered <= '0;
         eventcounter          <= '0;
      end else begin
         live_q  <= trigger_live;
         restart <= (acqstate == ACQ_IDLE) && trigger_live && !live_q;

         // Circular pointer, keeps going across records
         if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
         end

         case (acqstate)
            ACQ_IDLE: begin
               // Leave idle once the downsampler has restarted its groups
               if (restart) begin
                  cnt_q    <= '0;
                  post_q   <= 1'b0;
                  acqstate <= (prelengthtotake == '0) ? ACQ_ARMED : ACQ_PRE;
               end
            end
            ACQ_PRE: begin
               if (sample_valid) begin
                  if (cnt_next == prelengthtotake) begin
                     cnt_q    <= '0;
                     acqstate <= ACQ_ARMED;
                  end else begin
                     cnt_q <= cnt_next;
                  end
               end
            end
            ACQ_ARMED: begin
               if (sample_valid) begin
                  if (post_q) begin
                     // Post-trigger part of the record
                     if (cnt_next == lengthtotake) begin
                        post_q   <= 1'b0;
                        acqstate <= ACQ_DONE;
                     end else begin
                        cnt_q <= cnt_next;
                     end
                  end else if (trig) begin
                     ram_address_triggered <= wr_addr;
                     eventcounter          <= eventcounter + 1'b1;
                     cnt_q                 <= '0;
                     if (lengthtotake == '0) begin
                        acqstate <= ACQ_DONE;
                     end else begin
                        post_q <= 1'b1;
                     end
                  end
               end
            end
            ACQ_DONE: begin
               // Host drops trigger_live to rearm
               if (!trigger_live) begin
                  acqstate <= ACQ_IDLE;
               end
            end
            default: acqstate <= ACQ_IDLE;
         endcase
      end
   end

   // Record must fit in the RAM without overwriting its own start
   a_record_fits : assert property (
      @(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      restart |-> (32'(prelengthtotake) + 32'(lengthtotake) + 32'd1 <= (32'd1 << ADDR_W))
   );

endmodule

// File: verilog/threshold_trigger.sv
module threshold_trigger
   import scope_sample_pkg::*;
(
   input  logic    lvds_clk_slow_clkin,
   input  logic    rst_n,
   input  sample_t sample,
   input  logic    sample_valid,
   input  logic    armed,
   input  sample_t lowerthresh,
   input  sample_t upperthresh,
   output logic    trig
);

   logic below_seen;

   // Fires only after the signal has been low first
   assign trig = sample_valid && armed && below_seen && (sample >= upperthresh);

   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         below_seen <= 1'b0;
      end else if (!armed) begin
         below_seen <= 1'b0;
      end else if (sample_valid) begin
         if (trig) begin
            // Must see a low sample again before the next trigger
            below_seen <= 1'b0;
         end else if (sample <= lowerthresh) begin
            below_seen <= 1'b1;
         end
      end
   end

   // A trigger comes only from a valid sample while armed
   a_trig_armed : assert property (
      @(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      trig |-> (sample_valid && armed)
   );

endmodule

// File: verilog/downsampler.sv
module downsampler
   import scope_sample_pkg::*;
   import scope_acq_pkg::*;
(
   input  logic      lvds_clk_slow_clkin,
   input  logic      rst_n,
   input  adc_code_t rx_data,
   input  logic      restart,
   input  ds_shift_t downsample,
   input  logic      highres,
   output sample_t   sample,
   output logic      sample_valid
);

   logic [6:0] pos_q;
   logic [6:0] pos;
   logic [6:0] grp_last;
   logic       last_in_grp;
   sample_t    conv;
   sample_t    first_q;
   sample_t    pick;
   acc_t       acc_q;
   acc_t       acc_sum;

   always_comb begin
      // Offset binary to two's complement
      conv = sample_t'(rx_data) - sample_t'(ADC_MIDSCALE);

      // restart forces the current input to be the first of a group
      pos = restart ? '0 : pos_q;

      // Index of the last input in a group of 2**downsample
      grp_last = ~(7'h7f << downsample);
      last_in_grp = (pos == grp_last);

      // Running sum including this input
      if (pos == '0) begin
         acc_sum = acc_t'(conv);
      end else begin
         acc_sum = acc_q + acc_t'(conv);
      end

      pick = (pos == '0) ? conv : first_q;
   end

   // Group position and output strobe
   always_ff @(posedge lvds_clk_slow_clkin) begin
      if (!rst_n) begin
         pos_q        <= '0;
         sample_valid <= 1'b0;
      end else begin
         pos_q        <= last_in_grp ? '0 : pos + 7'd1;
         sample_valid <= last_in_grp;
      end
   end

   // Data path registers
   always_ff @(posedge lvds_clk_slow_clkin) begin
      acc_q <= acc_sum;
      if (pos == '0) begin
         first_q <= conv;
      end
      if (last_in_grp) begin
         // Average is the sum divided by the group size
         sample <= highres ? sample_t'(acc_sum >>> downsample) : pick;
      end
   end

   // Decimated output never comes on back-to-back cycles
   a_valid_spacing : assert property (
      @(posedge lvds_clk_slow_clkin) disable iff (!rst_n)
      (sample_valid && downsample != '0) |=> !sample_valid
   );

endmodule

// File: verilog/scope_acq_pkg.sv
package scope_acq_pkg;

   // Configuration field widths
   localparam int DS_SHIFT_W = 3;
   localparam int LEN_W      = 16;
   localparam int EVENT_W    = 32;

   // Acquisition state as seen by the host
   typedef enum logic [1:0] {
      ACQ_IDLE  = 2'd0,
      ACQ_PRE   = 2'd1,
      ACQ_ARMED = 2'd2,
      ACQ_DONE  = 2'd3
   } acq_state_t;

   // Decimation is by 2**downsample
   typedef logic [DS_SHIFT_W-1:0] ds_shift_t;

   // Pre and post record lengths in decimated samples
   typedef logic [LEN_W-1:0] len_t;

   // Number of triggered records since reset
   typedef logic [EVENT_W-1:0] event_count_t;

endpackage

// File: verilog/scope_sample_pkg.sv
package scope_sample_pkg;

   // Raw ADC word and the signed sample it becomes
   localparam int ADC_W    = 10;
   localparam int SAMPLE_W = 12;

   // Enough headroom to sum 128 full-scale samples
   localparam int ACC_W    = 19;

   // Offset-binary ADC code
   typedef logic [ADC_W-1:0] adc_code_t;

   // Two's complement sample, ADC code minus midscale
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // High-resolution averaging accumulator
   typedef logic signed [ACC_W-1:0] acc_t;

   // Code that maps to zero volts
   localparam adc_code_t ADC_MIDSCALE = adc_code_t'(512);

endpackage
